// ==== logic/rv32v_types_pkg.sv ====
/*
 * Shared types for the OPM vector execution slice.
 * Element and index widths, the OPM funct6 codes,
 * functional unit and ALU operation encodings, sequencer states.
 */

package rv32v_types_pkg;

    localparam int ELEM_W    = 32;
    localparam int NUM_VREGS = 8;
    localparam int VLMAX     = 8;

    typedef logic [ELEM_W-1:0]             elem_t;
    typedef logic [$clog2(NUM_VREGS)-1:0]  vreg_idx_t;
    typedef logic [$clog2(VLMAX)-1:0]      elem_idx_t;
    typedef logic [$clog2(VLMAX):0]        vl_t;       // 1..8 legal
    typedef logic [2:0]                    vfunct3_t;

    localparam vfunct3_t OPMVV = 3'd2;                  // only funct3 accepted

    // RVV 1.0 OPM funct6 codes for the supported subset
    typedef enum logic [5:0] {
        VREDSUM  = 6'b000000,
        VREDAND  = 6'b000001,
        VREDOR   = 6'b000010,
        VREDXOR  = 6'b000011,
        VREDMINU = 6'b000100,
        VREDMIN  = 6'b000101,
        VREDMAXU = 6'b000110,
        VREDMAX  = 6'b000111,
        VAADDU   = 6'b001000,
        VAADD    = 6'b001001,
        VASUBU   = 6'b001010,
        VASUB    = 6'b001011,
        VMANDN   = 6'b011000,
        VMAND    = 6'b011001,
        VMOR     = 6'b011010,
        VMXOR    = 6'b011011,
        VMNAND   = 6'b011101,
        VMNOR    = 6'b011110,
        VMXNOR   = 6'b011111
    } vfunct6_t;

    typedef enum logic [2:0] {
        VFU_ALU,
        VFU_RED,
        VFU_NONE
    } vfu_t;

    typedef enum logic [3:0] {
        VALU_ADD, VALU_SUB,
        VALU_AND, VALU_ANDN,
        VALU_OR, VALU_XOR,
        VALU_NAND, VALU_NOR, VALU_XNOR,
        VALU_MIN, VALU_MAX,
        VALU_AADD, VALU_ASUB
    } valuop_t;

    typedef enum logic [1:0] {
        SEQ_IDLE,
        SEQ_EXEC,
        SEQ_WB
    } seq_state_t;

endpackage

// ==== logic/rv32v_opm_decode.sv ====
/*
 * OPM funct6 decoder.
 * Maps vfunct6 and vfunct3 to a functional unit, an ALU
 * operation and the unsigned flag; flags anything else invalid.
 */

`timescale 1ns/1ps

module rv32v_opm_decode (
    input  rv32v_types_pkg::vfunct6_t vopm,
    input  rv32v_types_pkg::vfunct3_t vfunct3,
    output rv32v_types_pkg::vfu_t     vfu,
    output rv32v_types_pkg::valuop_t  valuop,
    output logic                      vopunsigned,
    output logic                      valid
);

    import rv32v_types_pkg::*;

    always_comb begin
        // defaults keep this latch free
        valid       = 1'b1;
        vfu         = VFU_NONE;
        valuop      = VALU_ADD;
        vopunsigned = 1'b0;

        case (vopm)
            VREDSUM: begin
                vfu    = VFU_RED;
                valuop = VALU_ADD;
            end
            VREDAND: begin
                vfu    = VFU_RED;
                valuop = VALU_AND;
            end
            VREDOR: begin
                vfu    = VFU_RED;
                valuop = VALU_OR;
            end
            VREDXOR: begin
                vfu    = VFU_RED;
                valuop = VALU_XOR;
            end
            VREDMINU: begin
                vfu         = VFU_RED;
                valuop      = VALU_MIN;
                vopunsigned = 1'b1;
            end
            VREDMIN: begin
                vfu    = VFU_RED;
                valuop = VALU_MIN;
            end
            VREDMAXU: begin
                vfu         = VFU_RED;
                valuop      = VALU_MAX;
                vopunsigned = 1'b1;
            end
            VREDMAX: begin
                vfu    = VFU_RED;
                valuop = VALU_MAX;
            end
            VAADDU: begin
                vfu         = VFU_ALU;
                valuop      = VALU_AADD;
                vopunsigned = 1'b1;
            end
            VAADD: begin
                vfu    = VFU_ALU;
                valuop = VALU_AADD;
            end
            VASUBU: begin
                vfu         = VFU_ALU;
                valuop      = VALU_ASUB;
                vopunsigned = 1'b1;
            end
            VASUB: begin
                vfu    = VFU_ALU;
                valuop = VALU_ASUB;
            end
            // mask logicals, applied to whole elements
            VMANDN: begin
                vfu    = VFU_ALU;
                valuop = VALU_ANDN;
            end
            VMAND: begin
                vfu    = VFU_ALU;
                valuop = VALU_AND;
            end
            VMOR: begin
                vfu    = VFU_ALU;
                valuop = VALU_OR;
            end
            VMXOR: begin
                vfu    = VFU_ALU;
                valuop = VALU_XOR;
            end
            VMNAND: begin
                vfu    = VFU_ALU;
                valuop = VALU_NAND;
            end
            VMNOR: begin
                vfu    = VFU_ALU;
                valuop = VALU_NOR;
            end
            VMXNOR: begin
                vfu    = VFU_ALU;
                valuop = VALU_XNOR;
            end
            default: begin
                valid = 1'b0;   // unsupported funct6
            end
        endcase

        if (vfunct3 != OPMVV) begin
            valid = 1'b0;       // OPMVX / OPFV etc not handled
        end
    end

endmodule

// ==== logic/vec_seq_fsm.sv ====
/*
 * Instruction sequencer.
 * Judges legality at issue, latches the instruction fields and
 * steps IDLE -> EXEC -> WB while driving register file and ALU controls.
 */

`timescale 1ns/1ps

module vec_seq_fsm (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       issue,
    input  rv32v_types_pkg::vreg_idx_t vd,
    input  rv32v_types_pkg::vreg_idx_t vs1,
    input  rv32v_types_pkg::vreg_idx_t vs2,
    input  rv32v_types_pkg::vl_t       vl,
    input  rv32v_types_pkg::vfu_t      vfu,
    input  rv32v_types_pkg::valuop_t   valuop,
    input  logic                       vopunsigned,
    input  logic                       valid,
    input  logic                       last,
    output logic                       busy,
    output logic                       done,
    output logic                       illegal,
    output logic                       cnt_start,
    output rv32v_types_pkg::vreg_idx_t rs1_reg,
    output rv32v_types_pkg::vreg_idx_t rs2_reg,
    output rv32v_types_pkg::vreg_idx_t wr_reg,
    output logic                       wr_first,
    output logic                       we,
    output logic                       acc_first,
    output logic                       acc_en,
    output rv32v_types_pkg::valuop_t   op,
    output logic                       op_unsigned,
    output logic                       is_red
);

    import rv32v_types_pkg::*;

    seq_state_t state;
    logic       legal;
    logic       accept;

    assign legal  = valid && (vfu != VFU_NONE) && (vl != '0) && (vl <= vl_t'(VLMAX));
    assign accept = (state == SEQ_IDLE) && issue && legal;

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= SEQ_IDLE;
            illegal   <= 1'b0;
            acc_first <= 1'b0;
        end else begin
            illegal   <= (state == SEQ_IDLE) && issue && !legal; // one-cycle pulse
            acc_first <= accept;                                 // high on first EXEC cycle
            case (state)
                SEQ_IDLE: if (accept) state <= SEQ_EXEC;
                SEQ_EXEC: if (last) state <= SEQ_WB;
                SEQ_WB:   state <= SEQ_IDLE;
                default:  state <= SEQ_IDLE;
            endcase
        end
    end

    // instruction fields, held for the whole run
    always_ff @(posedge clk) begin
        if (accept) begin
            rs1_reg     <= vs1;
            rs2_reg     <= vs2;
            wr_reg      <= vd;
            op          <= valuop;
            op_unsigned <= vopunsigned;
            is_red      <= (vfu == VFU_RED);
        end
    end

    assign cnt_start = accept;
    assign busy      = (state != SEQ_IDLE);
    assign done      = (state == SEQ_WB);
    assign acc_en    = (state == SEQ_EXEC) && is_red;
    assign wr_first  = is_red;                  // reductions land in element 0
    assign we        = ((state == SEQ_EXEC) && !is_red) || ((state == SEQ_WB) && is_red);

endmodule

// ==== logic/vec_elem_counter.sv ====
/*
 * Element index counter.
 * Loads the vector length on start and walks the index one element
 * per clock, flagging the last element.
 */

`timescale 1ns/1ps

module vec_elem_counter (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       start,
    input  rv32v_types_pkg::vl_t       vl,
    output rv32v_types_pkg::elem_idx_t elem_idx,
    output logic                       last
);

    import rv32v_types_pkg::*;

    vl_t len_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            len_q    <= '0;
            elem_idx <= '0;
        end else if (start) begin
            len_q    <= vl;
            elem_idx <= '0;
        end else begin
            elem_idx <= elem_idx + elem_idx_t'(1); // free running, sequencer ignores wrap
        end
    end

    assign last = (vl_t'(elem_idx) == len_q - vl_t'(1));

endmodule

// ==== logic/vec_elem_alu.sv ====
/*
 * Element ALU with reduction accumulator.
 * Applies the operation to src2 and a left operand, which is src1
 * or the running accumulator during reductions.
 */

`timescale 1ns/1ps

module vec_elem_alu (
    input  logic                      clk,
    input  logic                      reset,
    input  rv32v_types_pkg::elem_t    src1,
    input  rv32v_types_pkg::elem_t    src2,
    input  rv32v_types_pkg::valuop_t  op,
    input  logic                      op_unsigned,
    input  logic                      is_red,
    input  logic                      acc_first,
    input  logic                      acc_en,
    output rv32v_types_pkg::elem_t    result
);

    import rv32v_types_pkg::*;

    elem_t           acc_q;
    elem_t           lhs;
    elem_t           alu_val;
    logic [ELEM_W:0] ext2;
    logic [ELEM_W:0] ext1;
    logic [ELEM_W:0] avg_sum;
    logic [ELEM_W:0] avg_diff;
    logic            lt;

    assign lhs = (is_red && !acc_first) ? acc_q : src1;

    // 33-bit operands for the averaging forms
    assign ext2     = op_unsigned ? {1'b0, src2} : {src2[ELEM_W-1], src2};
    assign ext1     = op_unsigned ? {1'b0, lhs} : {lhs[ELEM_W-1], lhs};
    assign avg_sum  = ext2 + ext1;
    assign avg_diff = ext2 - ext1;

    assign lt = op_unsigned ? (src2 < lhs) : ($signed(src2) < $signed(lhs));

    always_comb begin
        case (op)
            VALU_ADD:  alu_val = src2 + lhs;
            VALU_SUB:  alu_val = src2 - lhs;
            VALU_AND:  alu_val = src2 & lhs;
            VALU_ANDN: alu_val = src2 & ~lhs;
            VALU_OR:   alu_val = src2 | lhs;
            VALU_XOR:  alu_val = src2 ^ lhs;
            VALU_NAND: alu_val = ~(src2 & lhs);
            VALU_NOR:  alu_val = ~(src2 | lhs);
            VALU_XNOR: alu_val = ~(src2 ^ lhs);
            VALU_MIN:  alu_val = lt ? src2 : lhs;
            VALU_MAX:  alu_val = lt ? lhs : src2;
            VALU_AADD: alu_val = avg_sum[ELEM_W:1];   // round down
            VALU_ASUB: alu_val = avg_diff[ELEM_W:1];
            default:   alu_val = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            acc_q <= '0;
        end else if (acc_en) begin
            acc_q <= alu_val;
        end
    end

    assign result = is_red ? acc_q : alu_val;

endmodule

// ==== logic/vec_regfile.sv ====
/*
 * Vector register file, eight registers of eight elements.
 * Two engine read ports, one host read port, one write port
 * shared by the engine and host loads.
 */

`timescale 1ns/1ps

module vec_regfile (
    input  logic                       clk,
    input  logic                       reset,
    input  rv32v_types_pkg::vreg_idx_t rs1_reg,
    input  rv32v_types_pkg::vreg_idx_t rs2_reg,
    input  rv32v_types_pkg::vreg_idx_t rd_reg,
    input  rv32v_types_pkg::elem_idx_t elem_idx,
    input  rv32v_types_pkg::elem_idx_t rd_idx,
    input  logic                       we,
    input  rv32v_types_pkg::vreg_idx_t wr_reg,
    input  logic                       wr_first,
    input  rv32v_types_pkg::elem_t     wr_data,
    input  logic                       load_en,
    input  rv32v_types_pkg::vreg_idx_t load_reg,
    input  rv32v_types_pkg::elem_idx_t load_idx,
    input  rv32v_types_pkg::elem_t     load_data,
    output rv32v_types_pkg::elem_t     rs1_data,
    output rv32v_types_pkg::elem_t     rs2_data,
    output rv32v_types_pkg::elem_t     rd_data
);

    import rv32v_types_pkg::*;

    elem_t     regs [NUM_VREGS][VLMAX];
    elem_idx_t wr_idx;

    assign wr_idx = wr_first ? '0 : elem_idx;

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int r = 0; r < NUM_VREGS; r++) begin
                for (int e = 0; e < VLMAX; e++) begin
                    regs[r][e] <= '0;
                end
            end
        end else if (we) begin
            regs[wr_reg][wr_idx] <= wr_data;       // engine beats host load
        end else if (load_en) begin
            regs[load_reg][load_idx] <= load_data;
        end
    end

    assign rs1_data = regs[rs1_reg][elem_idx];
    assign rs2_data = regs[rs2_reg][elem_idx];
    assign rd_data  = regs[rd_reg][rd_idx];

endmodule

// ==== logic/vec_opm_unit.sv ====
/*
 * OPM vector execution slice, top level.
 * Connects the decoder, sequencer, element counter, element ALU
 * and register file.
 */

`timescale 1ns/1ps

module vec_opm_unit (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       issue,
    input  rv32v_types_pkg::vfunct6_t  vfunct6,
    input  rv32v_types_pkg::vfunct3_t  vfunct3,
    input  rv32v_types_pkg::vreg_idx_t vd,
    input  rv32v_types_pkg::vreg_idx_t vs1,
    input  rv32v_types_pkg::vreg_idx_t vs2,
    input  rv32v_types_pkg::vl_t       vl,
    output logic                       busy,
    output logic                       done,
    output logic                       illegal,
    input  logic                       load_en,
    input  rv32v_types_pkg::vreg_idx_t load_reg,
    input  rv32v_types_pkg::elem_idx_t load_idx,
    input  rv32v_types_pkg::elem_t     load_data,
    input  rv32v_types_pkg::vreg_idx_t rd_reg,
    input  rv32v_types_pkg::elem_idx_t rd_idx,
    output rv32v_types_pkg::elem_t     rd_data
);

    import rv32v_types_pkg::*;

    vfu_t      vfu;
    valuop_t   valuop;
    logic      vopunsigned;
    logic      valid;
    logic      cnt_start;
    elem_idx_t elem_idx;
    logic      last;
    vreg_idx_t rs1_reg;
    vreg_idx_t rs2_reg;
    vreg_idx_t wr_reg;
    logic      wr_first;
    logic      we;
    logic      acc_first;
    logic      acc_en;
    valuop_t   op;
    logic      op_unsigned;
    logic      is_red;
    elem_t     rs1_data;
    elem_t     rs2_data;
    elem_t     alu_out;

    rv32v_opm_decode u_decode (
        .vopm(vfunct6), .vfunct3(vfunct3), .vfu(vfu), .valuop(valuop),
        .vopunsigned(vopunsigned), .valid(valid)
    );

    vec_seq_fsm u_seq (
        .clk(clk), .reset(reset), .issue(issue), .vd(vd), .vs1(vs1), .vs2(vs2), .vl(vl),
        .vfu(vfu), .valuop(valuop), .vopunsigned(vopunsigned), .valid(valid), .last(last),
        .busy(busy), .done(done), .illegal(illegal), .cnt_start(cnt_start),
        .rs1_reg(rs1_reg), .rs2_reg(rs2_reg), .wr_reg(wr_reg), .wr_first(wr_first),
        .we(we), .acc_first(acc_first), .acc_en(acc_en), .op(op),
        .op_unsigned(op_unsigned), .is_red(is_red)
    );

    vec_elem_counter u_counter (
        .clk(clk), .reset(reset), .start(cnt_start), .vl(vl),
        .elem_idx(elem_idx), .last(last)
    );

    vec_elem_alu u_alu (
        .clk(clk), .reset(reset), .src1(rs1_data), .src2(rs2_data), .op(op),
        .op_unsigned(op_unsigned), .is_red(is_red), .acc_first(acc_first),
        .acc_en(acc_en), .result(alu_out)
    );

    vec_regfile u_regfile (
        .clk(clk), .reset(reset), .rs1_reg(rs1_reg), .rs2_reg(rs2_reg), .rd_reg(rd_reg),
        .elem_idx(elem_idx), .rd_idx(rd_idx), .we(we), .wr_reg(wr_reg),
        .wr_first(wr_first), .wr_data(alu_out), .load_en(load_en), .load_reg(load_reg),
        .load_idx(load_idx), .load_data(load_data), .rs1_data(rs1_data),
        .rs2_data(rs2_data), .rd_data(rd_data)
    );

endmodule

// ==== tb/vec_opm_checker.sv ====
/*
 * Protocol assertions for the OPM vector slice.
 * Bound to the top level, watches the status pulses and
 * keeps a count of failed properties for the testbench.
 */

`timescale 1ns/1ps

module vec_opm_checker (
    input logic clk,
    input logic reset,
    input logic issue,
    input logic busy,
    input logic done,
    input logic illegal
);

    int fail_count = 0;     // read by the testbench at the end

    a_done_illegal_excl: assert property (@(posedge clk) disable iff (reset) !(done && illegal))
        else begin
            $error("done and illegal high in the same cycle");
            fail_count++;
        end

    a_done_after_busy: assert property (@(posedge clk) disable iff (reset) done |-> $past(busy))
        else begin
            $error("done without busy in the previous cycle");
            fail_count++;
        end

    a_illegal_after_issue: assert property (@(posedge clk) disable iff (reset)
        illegal |-> $past(issue))
        else begin
            $error("illegal without a preceding issue");
            fail_count++;
        end

    a_done_single: assert property (@(posedge clk) disable iff (reset) done |=> !done)
        else begin
            $error("done held for two cycles");
            fail_count++;
        end

    a_illegal_single: assert property (@(posedge clk) disable iff (reset) illegal |=> !illegal)
        else begin
            $error("illegal held for two cycles");
            fail_count++;
        end

endmodule

bind vec_opm_unit vec_opm_checker u_checker (
    .clk(clk), .reset(reset), .issue(issue), .busy(busy), .done(done), .illegal(illegal)
);

// ==== tb/tb_vec_opm_unit.sv ====
/*
 * Testbench for the OPM vector execution slice.
 * Random OPMVV instructions checked against a register mirror model.
 */

`timescale 1ns/1ps

module tb_vec_opm_unit;

    import rv32v_types_pkg::*;

    localparam int TIMEOUT = 40;

    logic      clk = 1'b0;
    logic      reset;
    logic      issue;
    vfunct6_t  vfunct6;
    vfunct3_t  vfunct3;
    vreg_idx_t vd, vs1, vs2;
    vl_t       vl;
    logic      busy, done, illegal;
    logic      load_en;
    vreg_idx_t load_reg, rd_reg;
    elem_idx_t load_idx, rd_idx;
    elem_t     load_data, rd_data;

    elem_t model [64];      // mirror of all registers, index {reg, elem}
    int    seed = 32'h4933;
    int    errors = 0;
    int    mark = 0;
    int    npass = 0;
    int    nfail = 0;

    vfunct6_t ew_ops [11] = '{VAADDU, VAADD, VASUBU, VASUB, VMANDN, VMAND,
                              VMOR, VMXOR, VMNAND, VMNOR, VMXNOR};
    vfunct6_t red_ops [8] = '{VREDSUM, VREDAND, VREDOR, VREDXOR,
                              VREDMINU, VREDMIN, VREDMAXU, VREDMAX};
    elem_t    corner [4]  = '{32'h7fffffff, 32'h80000000, 32'hffffffff, 32'h00000001};

    vec_opm_unit u_vec_opm_unit (.*);

    always #5 clk = ~clk;

    // x comes from vs2, y from vs1 or the running accumulator
    function automatic elem_t ref_op(input vfunct6_t f, input elem_t x, input elem_t y);
        logic [ELEM_W:0] s;
        s = '0;
        case (f)
            VREDSUM:        return x + y;
            VREDAND, VMAND: return x & y;
            VREDOR, VMOR:   return x | y;
            VREDXOR, VMXOR: return x ^ y;
            VREDMINU:       return (x < y) ? x : y;
            VREDMIN:        return ($signed(x) < $signed(y)) ? x : y;
            VREDMAXU:       return (x > y) ? x : y;
            VREDMAX:        return ($signed(x) > $signed(y)) ? x : y;
            VAADDU:         s = {1'b0, x} + {1'b0, y};
            VAADD:          s = {x[ELEM_W-1], x} + {y[ELEM_W-1], y};
            VASUBU:         s = {1'b0, x} - {1'b0, y};
            VASUB:          s = {x[ELEM_W-1], x} - {y[ELEM_W-1], y};
            VMANDN:         return x & ~y;
            VMNAND:         return ~(x & y);
            VMNOR:          return ~(x | y);
            VMXNOR:         return ~(x ^ y);
            default:        return '0;
        endcase
        return s[ELEM_W:1];     // round down average
    endfunction

    function automatic vreg_idx_t rnd_reg();
        return vreg_idx_t'($random(seed));
    endfunction

    function automatic vl_t rnd_vl();
        return vl_t'({$random(seed)} % 8 + 1);
    endfunction

    task automatic check_elem(input elem_t got, input elem_t exp, input string what);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %b expected %b", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic load_elem(input vreg_idx_t r, input elem_idx_t e, input elem_t data);
        load_en   = 1'b1;
        load_reg  = r;
        load_idx  = e;
        load_data = data;
        @(posedge clk);
        #1;
        load_en = 1'b0;
        model[{r, e}] = data;
    endtask

    task automatic fill_random();
        for (int i = 0; i < 64; i++) begin
            load_elem(vreg_idx_t'(i / 8), elem_idx_t'(i % 8), elem_t'($random(seed)));
        end
    endtask

    task automatic read_check(input vreg_idx_t r, input elem_idx_t e);
        rd_reg = r;
        rd_idx = e;
        @(posedge clk);
        #1;
        check_elem(rd_data, model[{r, e}], $sformatf("v%0d[%0d]", r, e));
    endtask

    task automatic read_all();
        for (int i = 0; i < 64; i++) begin
            read_check(vreg_idx_t'(i / 8), elem_idx_t'(i % 8));
        end
    endtask

    task automatic apply_model(input vfunct6_t f, input vreg_idx_t d, s1, s2, input vl_t n);
        elem_t a [8];
        elem_t b [8];
        elem_t acc;
        for (int i = 0; i < 8; i++) begin
            a[i] = model[{s1, elem_idx_t'(i)}];
            b[i] = model[{s2, elem_idx_t'(i)}];
        end
        if (f[5:3] == 3'b000) begin     // reductions sit at funct6 0..7
            acc = a[0];
            for (int i = 0; i < n; i++) begin
                acc = ref_op(f, b[i], acc);
            end
            model[{d, 3'b000}] = acc;
        end else begin
            for (int i = 0; i < n; i++) begin
                model[{d, elem_idx_t'(i)}] = ref_op(f, b[i], a[i]);
            end
        end
    endtask

    task automatic run_op(input vfunct6_t f, input vfunct3_t f3, input vreg_idx_t d, s1, s2,
                          input vl_t n, input logic legal);
        int cyc;
        vfunct6 = f;
        vfunct3 = f3;
        vd      = d;
        vs1     = s1;
        vs2     = s2;
        vl      = n;
        issue   = 1'b1;
        @(posedge clk);
        #1;
        issue = 1'b0;
        cyc   = 1;
        if (legal) begin
            while (!done && cyc < TIMEOUT) begin
                @(posedge clk);
                #1;
                cyc++;
            end
            if (!done) begin
                $display("timeout: no done for funct6 %h vl %0d", f, n);
                errors++;
            end else begin
                check_flag(cyc == n + 1, 1'b1, "done latency");
                apply_model(f, d, s1, s2, n);
            end
            @(posedge clk);             // write-back edge
            #1;
            check_flag(busy, 1'b0, "busy after done");
        end else begin
            while (!illegal && cyc < TIMEOUT) begin
                @(posedge clk);
                #1;
                cyc++;
            end
            if (!illegal) begin
                $display("timeout: no illegal pulse for funct6 %h funct3 %0d", f, f3);
                errors++;
            end else begin
                check_flag(cyc == 1, 1'b1, "illegal timing");
            end
            for (int i = 0; i < 12; i++) begin
                check_flag(done || busy, 1'b0, "activity after reject");
                @(posedge clk);
                #1;
            end
        end
        read_all();
    endtask

    task automatic end_test(input string name);
        if (errors == mark) begin
            npass++;
            $display("test %s: pass", name);
        end else begin
            nfail++;
            $display("test %s: fail, %0d errors", name, errors - mark);
        end
        mark = errors;
    endtask

    initial begin
        int ndone;
        int nill;
        reset     = 1'b1;
        issue     = 1'b0;
        vfunct6   = VREDSUM;
        vfunct3   = OPMVV;
        vd        = '0;
        vs1       = '0;
        vs2       = '0;
        vl        = vl_t'(1);
        load_en   = 1'b0;
        load_reg  = '0;
        load_idx  = '0;
        load_data = '0;
        rd_reg    = '0;
        rd_idx    = '0;
        for (int i = 0; i < 64; i++) begin
            model[i] = '0;
        end
        repeat (10) @(posedge clk);
        #1;
        reset = 1'b0;

        for (int i = 0; i < 8; i++) begin
            read_check(rnd_reg(), elem_idx_t'($random(seed)));
        end
        for (int i = 0; i < 16; i++) begin
            load_elem(rnd_reg(), elem_idx_t'($random(seed)), elem_t'($random(seed)));
        end
        read_all();
        end_test("reset_load");

        fill_random();
        foreach (ew_ops[k]) begin
            repeat (2) run_op(ew_ops[k], OPMVV, rnd_reg(), rnd_reg(), rnd_reg(), rnd_vl(), 1'b1);
        end
        end_test("elementwise");

        fill_random();
        foreach (red_ops[k]) begin
            run_op(red_ops[k], OPMVV, rnd_reg(), rnd_reg(), rnd_reg(), rnd_vl(), 1'b1);
        end
        end_test("reduction");

        for (int i = 0; i < 8; i++) begin
            load_elem(3'd1, elem_idx_t'(i), corner[{$random(seed)} % 4]);
            load_elem(3'd2, elem_idx_t'(i), corner[{$random(seed)} % 4]);
        end
        run_op(VAADD, OPMVV, 3'd3, 3'd1, 3'd2, vl_t'(8), 1'b1);
        run_op(VAADDU, OPMVV, 3'd3, 3'd1, 3'd2, vl_t'(8), 1'b1);
        run_op(VASUB, OPMVV, 3'd3, 3'd1, 3'd2, vl_t'(8), 1'b1);
        run_op(VASUBU, OPMVV, 3'd3, 3'd1, 3'd2, vl_t'(8), 1'b1);
        end_test("average_corners");

        run_op(vfunct6_t'(6'b010000), OPMVV, 3'd0, 3'd1, 3'd2, vl_t'(4), 1'b0); // mask unary
        run_op(vfunct6_t'(6'b100101), OPMVV, 3'd0, 3'd1, 3'd2, vl_t'(4), 1'b0); // vmul
        run_op(vfunct6_t'(6'b011100), OPMVV, 3'd0, 3'd1, 3'd2, vl_t'(4), 1'b0); // vmorn
        run_op(VREDSUM, 3'd6, 3'd0, 3'd1, 3'd2, vl_t'(4), 1'b0);               // OPMVX
        run_op(VAADD, 3'd5, 3'd0, 3'd1, 3'd2, vl_t'(4), 1'b0);
        run_op(VMAND, OPMVV, 3'd0, 3'd1, 3'd2, vl_t'(0), 1'b0);
        run_op(VMOR, OPMVV, 3'd0, 3'd1, 3'd2, vl_t'(9 + {$random(seed)} % 7), 1'b0);
        end_test("reject");

        vfunct6 = VMXOR;
        vfunct3 = OPMVV;
        vd      = 3'd4;
        vs1     = 3'd5;
        vs2     = 3'd6;
        vl      = vl_t'(8);
        issue   = 1'b1;
        @(posedge clk);
        #1;
        issue = 1'b0;
        @(posedge clk);
        #1;
        vfunct6 = VREDSUM;              // second issue lands mid-run
        vd      = 3'd7;
        vl      = vl_t'(2);
        issue   = 1'b1;
        @(posedge clk);
        #1;
        issue = 1'b0;
        ndone = 0;
        nill  = 0;
        for (int i = 0; i < TIMEOUT; i++) begin
            ndone += done;
            nill  += illegal;
            @(posedge clk);
            #1;
        end
        check_flag(ndone == 1, 1'b1, "one done for two issues");
        check_flag(nill == 0, 1'b1, "no illegal for busy issue");
        apply_model(VMXOR, 3'd4, 3'd5, 3'd6, vl_t'(8));
        read_all();
        end_test("issue_busy");

        if (u_vec_opm_unit.u_checker.fail_count != 0) begin
            $display("protocol checker saw %0d failed assertions",
                     u_vec_opm_unit.u_checker.fail_count);
            errors += u_vec_opm_unit.u_checker.fail_count;
        end

        $display("tests passed %0d failed %0d, %0d errors", npass, nfail, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== sources.f ====
logic/rv32v_types_pkg.sv
logic/rv32v_opm_decode.sv
logic/vec_seq_fsm.sv
logic/vec_elem_counter.sv
logic/vec_elem_alu.sv
logic/vec_regfile.sv
logic/vec_opm_unit.sv
tb/vec_opm_checker.sv
tb/tb_vec_opm_unit.sv
